// File: bench/csr_tb.sv
/*
 * Testbench for the CSR subsystem.
 * Acts as the single initiator: one request at a time, the next one only
 * after the response pulse. Expected responses come from a reference
 * model of the three banks. Random stimulus uses a fixed seed.
 */
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_tb
  import csr_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 20;
  localparam int RANDOM_ACCESSES = 200;

  logic      clk;
  logic      rst;
  logic      req_valid;
  logic      req_write;
  csr_addr_t req_addr;
  csr_data_t req_wdata;
  csr_strb_t req_wstrb;
  logic      req_privileged;
  logic      req_secure;
  logic      req_abort;
  logic      resp_valid;
  csr_data_t resp_rdata;
  logic      resp_decerr;
  logic      resp_slverr;

  integer seed = 32'hfc04;
  int     errors;
  int     tests_passed;
  int     tests_failed;
  int     test_errors_at_start;
  string  test_name;

  // Reference copy of the storage words 0 to 2 of every bank
  csr_data_t model [`CSR_NUM_BANKS][3];

  csr_subsystem dut0 (
    .clk            (clk),
    .rst            (rst),
    .req_valid      (req_valid),
    .req_write      (req_write),
    .req_addr       (req_addr),
    .req_wdata      (req_wdata),
    .req_wstrb      (req_wstrb),
    .req_privileged (req_privileged),
    .req_secure     (req_secure),
    .req_abort      (req_abort),
    .resp_valid     (resp_valid),
    .resp_rdata     (resp_rdata),
    .resp_decerr    (resp_decerr),
    .resp_slverr    (resp_slverr)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] next_random();
    return $random(seed);
  endfunction

  // Bank index of an address, -1 when no range matches
  function automatic int bank_of(input csr_addr_t addr);
    if (addr >= `CSR_BANK0_BASE && addr <= `CSR_BANK0_LIMIT) return 0;
    if (addr >= `CSR_BANK1_BASE && addr <= `CSR_BANK1_LIMIT) return 1;
    if (addr >= `CSR_BANK2_BASE && addr <= `CSR_BANK2_LIMIT) return 2;
    return -1;
  endfunction

  // Round trip is one bank cycle plus both retimers
  function automatic int latency_of(input int bank);
    int stages;
    case (bank)
      0: stages = `CSR_BANK0_STAGES;
      1: stages = `CSR_BANK1_STAGES;
      2: stages = `CSR_BANK2_STAGES;
      default: stages = 0;
    endcase
    return 1 + 2 * stages;
  endfunction

  // Random byte address inside the given word of a bank
  function automatic csr_addr_t bank_addr(input int bank, input int word);
    logic [31:0] r;
    csr_addr_t   base;
    r = next_random();
    case (bank)
      0: base = `CSR_BANK0_BASE;
      1: base = `CSR_BANK1_BASE;
      2: base = `CSR_BANK2_BASE;
      default: base = '0;
    endcase
    return base + csr_addr_t'({word[1:0], r[1:0]});
  endfunction

  // Random address that hits no bank
  function automatic csr_addr_t gap_addr();
    logic [31:0] r;
    csr_addr_t   a;
    r = next_random();
    a = r[7:0];
    while (bank_of(a) >= 0) begin
      r = next_random();
      a = r[7:0];
    end
    return a;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, expected, actual);
    errors++;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errors_at_start = errors;
  endtask

  task automatic finish_test();
    if (errors == test_errors_at_start) begin
      tests_passed++;
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, errors - test_errors_at_start);
    end
  endtask

  // One request and its response; starts and ends 1 ns after a rising edge
  task automatic run_access(input logic write, input csr_addr_t addr, input csr_data_t wdata,
                            input csr_strb_t wstrb, input logic priv, input logic sec,
                            input logic abort);
    int        bank;
    int        word;
    int        exp_lat;
    int        cycles;
    bit        seen;
    logic      violation;
    csr_data_t exp_rdata;
    logic      exp_decerr;
    logic      exp_slverr;
    bank = bank_of(addr);
    word = int'(addr[3:2]);
    exp_lat = latency_of(bank);
    exp_rdata = '0;
    exp_decerr = 1'b0;
    exp_slverr = 1'b0;
    violation = 1'b0;
    if (bank < 0) begin
      exp_decerr = 1'b1;
    end else if (!abort) begin
      case (word)
        1: violation = write && !priv;
        2: violation = !sec;
        3: violation = write;
        default: violation = 1'b0;
      endcase
      if (violation) begin
        exp_slverr = 1'b1;
      end else if (write) begin
        for (int b = 0; b < `CSR_STRB_W; b++) begin
          if (wstrb[b]) begin
            model[bank][word][8*b +: 8] = wdata[8*b +: 8];
          end
        end
      end else if (word == 3) begin
        exp_rdata = csr_data_t'(bank);
      end else begin
        exp_rdata = model[bank][word];
      end
    end

    req_valid = 1'b1;
    req_write = write;
    req_addr = addr;
    req_wdata = wdata;
    req_wstrb = wstrb;
    req_privileged = priv;
    req_secure = sec;
    req_abort = abort;
    cycles = 0;
    seen = 0;
    while (!seen && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      #1;
      cycles++;
      if (resp_valid) begin
        seen = 1;
      end
      if (cycles == 1) begin
        req_valid = 1'b0;
        req_abort = 1'b0;
      end
    end

    if (!seen) begin
      $display("Timeout: no response within %0d cycles for a request to address %h",
               TIMEOUT_CYCLES, addr);
      errors++;
    end else begin
      if (cycles != exp_lat) begin
        report_mismatch("resp_valid latency", 32'(exp_lat), 32'(cycles));
      end
      if (resp_rdata !== exp_rdata) begin
        report_mismatch("resp_rdata", exp_rdata, resp_rdata);
      end
      if (resp_decerr !== exp_decerr) begin
        report_mismatch("resp_decerr", 32'(exp_decerr), 32'(resp_decerr));
      end
      if (resp_slverr !== exp_slverr) begin
        report_mismatch("resp_slverr", 32'(exp_slverr), 32'(resp_slverr));
      end
      // The response is a single-cycle pulse
      @(posedge clk);
      #1;
      if (resp_valid !== 1'b0) begin
        report_mismatch("resp_valid after pulse", 32'(0), 32'(resp_valid));
      end
    end
  endtask

  // Secure privileged read of every storage word, compared with the model
  task automatic read_all_words();
    for (int b = 0; b < `CSR_NUM_BANKS; b++) begin
      for (int w = 0; w < 3; w++) begin
        run_access(1'b0, bank_addr(b, w), '0, '0, 1'b1, 1'b1, 1'b0);
      end
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] d;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    for (int b = 0; b < `CSR_NUM_BANKS; b++) begin
      for (int w = 0; w < 3; w++) begin
        model[b][w] = '0;
      end
    end
    clk = 1'b0;
    rst = 1'b1;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr = '0;
    req_wdata = '0;
    req_wstrb = '0;
    req_privileged = 1'b0;
    req_secure = 1'b0;
    req_abort = 1'b0;

    start_test("reset state");
    for (int i = 0; i < 12; i++) begin
      @(posedge clk);
      #1;
      if (i == 3) begin
        rst = 1'b0;
      end
      if (i > 0 && resp_valid !== 1'b0) begin
        report_mismatch("resp_valid", 32'(0), 32'(resp_valid));
      end
    end
    read_all_words();
    finish_test();

    start_test("word 0 strobed writes");
    for (int i = 0; i < 6; i++) begin
      for (int b = 0; b < `CSR_NUM_BANKS; b++) begin
        d = next_random();
        r = next_random();
        run_access(1'b1, bank_addr(b, 0), d, r[3:0], r[4], r[5], 1'b0);
        run_access(1'b0, bank_addr(b, 0), '0, '0, r[6], r[7], 1'b0);
      end
    end
    finish_test();

    start_test("decode errors");
    for (int i = 0; i < 20; i++) begin
      d = next_random();
      r = next_random();
      run_access(r[0], gap_addr(), d, r[4:1], r[5], r[6], r[7]);
    end
    read_all_words();
    finish_test();

    start_test("words 1 and 2 protection");
    for (int b = 0; b < `CSR_NUM_BANKS; b++) begin
      run_access(1'b1, bank_addr(b, 1), next_random(), 4'hf, 1'b1, 1'b0, 1'b0);
      run_access(1'b1, bank_addr(b, 1), next_random(), 4'hf, 1'b0, 1'b1, 1'b0);
      run_access(1'b0, bank_addr(b, 1), '0, '0, 1'b0, 1'b0, 1'b0);
      run_access(1'b1, bank_addr(b, 2), next_random(), 4'hf, 1'b0, 1'b1, 1'b0);
      run_access(1'b0, bank_addr(b, 2), '0, '0, 1'b1, 1'b0, 1'b0);
      run_access(1'b1, bank_addr(b, 2), next_random(), 4'hf, 1'b1, 1'b0, 1'b0);
      run_access(1'b0, bank_addr(b, 2), '0, '0, 1'b0, 1'b1, 1'b0);
    end
    finish_test();

    start_test("word 3 bank id");
    for (int b = 0; b < `CSR_NUM_BANKS; b++) begin
      r = next_random();
      run_access(1'b0, bank_addr(b, 3), '0, '0, r[0], r[1], 1'b0);
      run_access(1'b1, bank_addr(b, 3), next_random(), 4'hf, 1'b1, 1'b1, 1'b0);
      run_access(1'b0, bank_addr(b, 3), '0, '0, r[2], r[3], 1'b0);
    end
    finish_test();

    start_test("aborted requests");
    for (int b = 0; b < `CSR_NUM_BANKS; b++) begin
      run_access(1'b1, bank_addr(b, 0), next_random(), 4'hf, 1'b1, 1'b1, 1'b0);
      run_access(1'b1, bank_addr(b, 0), next_random(), 4'hf, 1'b1, 1'b1, 1'b1);
      run_access(1'b0, bank_addr(b, 0), '0, '0, 1'b1, 1'b1, 1'b0);
      // Abort also hides a protection fault
      run_access(1'b1, bank_addr(b, 1), next_random(), 4'hf, 1'b0, 1'b0, 1'b1);
      run_access(1'b0, bank_addr(b, 3), '0, '0, 1'b1, 1'b1, 1'b1);
    end
    read_all_words();
    finish_test();

    start_test("random mix");
    for (int i = 0; i < RANDOM_ACCESSES; i++) begin
      d = next_random();
      r = next_random();
      if (r[10:8] < 3'd6) begin
        run_access(r[0], bank_addr(int'(r[15:12] % 4'd3), int'(r[17:16])), d, r[21:18],
                   r[1], r[2], r[5:3] == 3'd0);
      end else begin
        run_access(r[0], gap_addr(), d, r[21:18], r[1], r[2], r[5:3] == 3'd0);
      end
    end
    read_all_words();
    finish_test();

    $display("tests passed %0d, tests failed %0d, check errors %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/csr_addr_decode.sv
/*
 * Combinational address decoder for the CSR demux.
 * Ranges are fixed at build time by the config header. The tables below
 * hold three entries and must grow with CSR_NUM_BANKS.
 * miss is only raised for a valid request that hits no range.
 */
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_addr_decode
  import csr_pkg::*;
(
  input  csr_addr_t addr,
  input  logic      valid,
  output csr_sel_t  sel,
  output logic      miss
);

  localparam csr_addr_t BANK_BASE [`CSR_NUM_BANKS] = '{
    `CSR_BANK0_BASE, `CSR_BANK1_BASE, `CSR_BANK2_BASE
  };
  localparam csr_addr_t BANK_LIMIT [`CSR_NUM_BANKS] = '{
    `CSR_BANK0_LIMIT, `CSR_BANK1_LIMIT, `CSR_BANK2_LIMIT
  };

  always_comb begin
    for (int i = 0; i < `CSR_NUM_BANKS; i++) begin
      sel[i] = (addr >= BANK_BASE[i]) && (addr <= BANK_LIMIT[i]);
    end
  end

  // Unmatched requests are answered by the decode-error path
  assign miss = valid && !(|sel);

  // Disjoint ranges keep sel one-hot for any address
  initial begin
    for (int i = 0; i < `CSR_NUM_BANKS; i++) begin
      a_range_order: assert (BANK_BASE[i] <= BANK_LIMIT[i])
        else $error("bank %0d range has base above limit", i);
      for (int j = i + 1; j < `CSR_NUM_BANKS; j++) begin
        a_range_disjoint: assert ((BANK_LIMIT[i] < BANK_BASE[j]) ||
                                  (BANK_BASE[i] > BANK_LIMIT[j]))
          else $error("bank %0d and bank %0d ranges overlap", i, j);
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/csr_config.svh
/*
 * Build-time configuration of the CSR fabric.
 * Bank ranges are inclusive byte addresses. They must not overlap and
 * each must span at least the four words of a register bank.
 * Adding a bank also needs a new range and stage pair here and an extra
 * entry in the decoder and demux tables.
 */
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// Bus widths
`define CSR_ADDR_W 8
`define CSR_DATA_W 32
`define CSR_STRB_W 4

`define CSR_NUM_BANKS 3

// Inclusive address ranges per bank
`define CSR_BANK0_BASE  8'h00
`define CSR_BANK0_LIMIT 8'h0F
`define CSR_BANK1_BASE  8'h10
`define CSR_BANK1_LIMIT 8'h1F
`define CSR_BANK2_BASE  8'h40
`define CSR_BANK2_LIMIT 8'h4F

// Retime stages on each direction of a bank path
`define CSR_BANK0_STAGES 0
`define CSR_BANK1_STAGES 1
`define CSR_BANK2_STAGES 2

`endif

// File: hdl/csr_demux.sv
/*
 * Routes each request to one bank by address and merges the answers.
 * Every bank path has its own request and response retimer, both with
 * the bank's stage count, so round trip is 1 + 2 * stages cycles.
 * No back-pressure and no default bank. Unmatched requests get decerr.
 */
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_demux
  import csr_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           req_valid,
  input  logic                           req_write,
  input  csr_addr_t                      req_addr,
  input  csr_data_t                      req_wdata,
  input  csr_strb_t                      req_wstrb,
  input  logic                           req_privileged,
  input  logic                           req_secure,
  input  logic                           req_abort,
  output logic                           resp_valid,
  output csr_data_t                      resp_rdata,
  output logic                           resp_decerr,
  output logic                           resp_slverr,
  output logic      [`CSR_NUM_BANKS-1:0] bank_req_valid,
  output logic      [`CSR_NUM_BANKS-1:0] bank_req_write,
  output csr_addr_t [`CSR_NUM_BANKS-1:0] bank_req_addr,
  output csr_data_t [`CSR_NUM_BANKS-1:0] bank_req_wdata,
  output csr_strb_t [`CSR_NUM_BANKS-1:0] bank_req_wstrb,
  output logic      [`CSR_NUM_BANKS-1:0] bank_req_privileged,
  output logic      [`CSR_NUM_BANKS-1:0] bank_req_secure,
  output logic      [`CSR_NUM_BANKS-1:0] bank_req_abort,
  input  logic      [`CSR_NUM_BANKS-1:0] bank_resp_valid,
  input  csr_data_t [`CSR_NUM_BANKS-1:0] bank_resp_rdata,
  input  logic      [`CSR_NUM_BANKS-1:0] bank_resp_decerr,
  input  logic      [`CSR_NUM_BANKS-1:0] bank_resp_slverr
);

  localparam int BANK_STAGES [`CSR_NUM_BANKS] = '{
    `CSR_BANK0_STAGES, `CSR_BANK1_STAGES, `CSR_BANK2_STAGES
  };
  // write, addr, wdata, wstrb, privileged, secure
  localparam int REQ_W  = 3 + `CSR_ADDR_W + `CSR_DATA_W + `CSR_STRB_W;
  localparam int RESP_W = `CSR_DATA_W + 2;

  csr_sel_t                         sel;
  logic                             miss;
  logic [REQ_W-1:0]                 req_fields;
  logic [`CSR_NUM_BANKS-1:0]        rt_resp_valid;
  csr_data_t [`CSR_NUM_BANKS-1:0]   rt_resp_rdata;
  logic [`CSR_NUM_BANKS-1:0]        rt_resp_decerr;
  logic [`CSR_NUM_BANKS-1:0]        rt_resp_slverr;

  csr_addr_decode u_decode (
    .addr  (req_addr),
    .valid (req_valid),
    .sel   (sel),
    .miss  (miss)
  );

  assign req_fields = {req_write, req_addr, req_wdata, req_wstrb, req_privileged, req_secure};

  for (genvar i = 0; i < `CSR_NUM_BANKS; i++) begin : gen_bank
    logic [REQ_W-1:0]  req_out;
    logic [RESP_W-1:0] resp_out;

    // Abort rides outside the valid qualifier, banks gate it themselves
    csr_retime #(.STAGES(BANK_STAGES[i]), .WIDTH(REQ_W)) u_req_retime (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (req_valid && sel[i]),
      .in_data   (req_fields),
      .in_abort  (req_abort),
      .out_valid (bank_req_valid[i]),
      .out_data  (req_out),
      .out_abort (bank_req_abort[i])
    );

    assign {bank_req_write[i], bank_req_addr[i], bank_req_wdata[i], bank_req_wstrb[i],
            bank_req_privileged[i], bank_req_secure[i]} = req_out;

    csr_retime #(.STAGES(BANK_STAGES[i]), .WIDTH(RESP_W)) u_resp_retime (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (bank_resp_valid[i]),
      .in_data   ({bank_resp_rdata[i], bank_resp_decerr[i], bank_resp_slverr[i]}),
      .in_abort  (1'b0),
      .out_valid (rt_resp_valid[i]),
      .out_data  (resp_out),
      .out_abort ()
    );

    assign {rt_resp_rdata[i], rt_resp_decerr[i], rt_resp_slverr[i]} = resp_out;
  end

  csr_resp_mux u_result (
    .clk         (clk),
    .rst         (rst),
    .miss        (miss),
    .bank_valid  (rt_resp_valid),
    .bank_rdata  (rt_resp_rdata),
    .bank_decerr (rt_resp_decerr),
    .bank_slverr (rt_resp_slverr),
    .resp_valid  (resp_valid),
    .resp_rdata  (resp_rdata),
    .resp_decerr (resp_decerr),
    .resp_slverr (resp_slverr)
  );

endmodule

`default_nettype wire

// File: hdl/csr_pkg.sv
/*
 * Shared types of the CSR fabric.
 * Widths come from the config header, so every file sees the same bus.
 */
`default_nettype none

`include "csr_config.svh"

package csr_pkg;

  // Request and response payload vectors
  typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [`CSR_DATA_W-1:0] csr_data_t;
  typedef logic [`CSR_STRB_W-1:0] csr_strb_t;

  // One bit per downstream bank, at most one bit set
  typedef logic [`CSR_NUM_BANKS-1:0] csr_sel_t;

endpackage

`default_nettype wire

// File: hdl/csr_reg_bank.sv
/*
 * Four-word CSR bank, word chosen by address bits [3:2].
 * Word 0 open, word 1 needs privilege to write, word 2 needs secure for
 * any access, word 3 reads BANK_ID and rejects writes with slverr.
 * Writes and aborted requests answer with rdata zero.
 * Response comes one cycle after the request, always without decerr.
 */
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_reg_bank
  import csr_pkg::*;
#(
  parameter int BANK_ID = 0
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      req_valid,
  input  logic      req_write,
  input  csr_addr_t req_addr,
  input  csr_data_t req_wdata,
  input  csr_strb_t req_wstrb,
  input  logic      req_privileged,
  input  logic      req_secure,
  input  logic      req_abort,
  output logic      resp_valid,
  output csr_data_t resp_rdata,
  output logic      resp_decerr,
  output logic      resp_slverr
);

  // Word 3 is the constant ID and needs no storage
  localparam int        NUM_RW_WORDS = 3;
  localparam csr_data_t ID_WORD      = csr_data_t'(BANK_ID);

  csr_data_t  regs [NUM_RW_WORDS];
  logic [1:0] word_idx;
  logic       access_err;
  logic       wr_en;
  csr_data_t  rd_word;

  assign word_idx = req_addr[3:2];

  // Per-word protection and read value
  always_comb begin
    access_err = 1'b0;
    rd_word    = '0;
    case (word_idx)
      2'd0: rd_word = regs[0];
      2'd1: begin
        rd_word    = regs[1];
        access_err = req_write && !req_privileged;
      end
      2'd2: begin
        rd_word    = regs[2];
        access_err = !req_secure;
      end
      default: begin
        rd_word    = ID_WORD;
        access_err = req_write;
      end
    endcase
  end

  assign wr_en = req_valid && req_write && !req_abort && !access_err;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < NUM_RW_WORDS; w++) begin
        regs[w] <= '0;
      end
    end else if (wr_en) begin
      for (int w = 0; w < NUM_RW_WORDS; w++) begin
        for (int b = 0; b < `CSR_STRB_W; b++) begin
          if ((word_idx == 2'(w)) && req_wstrb[b]) begin
            regs[w][8*b +: 8] <= req_wdata[8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= req_valid;
    end
  end

  // Abort wins over a protection fault
  always_ff @(posedge clk) begin
    if (req_valid) begin
      resp_slverr <= !req_abort && access_err;
      if (req_abort || access_err || req_write) begin
        resp_rdata <= '0;
      end else begin
        resp_rdata <= rd_word;
      end
    end
  end

  assign resp_decerr = 1'b0;

endmodule

`default_nettype wire

// File: hdl/csr_resp_mux.sv
/*
 * Upstream response select for the CSR demux.
 * A miss becomes a decerr response one cycle later with rdata zero.
 * Bank responses pass straight through. Relies on the initiator keeping
 * a single request outstanding, so at most one source is valid.
 */
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_resp_mux
  import csr_pkg::*;
(
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              miss,
  input  csr_sel_t                          bank_valid,
  input  csr_data_t [`CSR_NUM_BANKS-1:0]    bank_rdata,
  input  logic      [`CSR_NUM_BANKS-1:0]    bank_decerr,
  input  logic      [`CSR_NUM_BANKS-1:0]    bank_slverr,
  output logic                              resp_valid,
  output csr_data_t                         resp_rdata,
  output logic                              resp_decerr,
  output logic                              resp_slverr
);

  logic decerr_valid_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      decerr_valid_q <= 1'b0;
    end else begin
      decerr_valid_q <= miss;
    end
  end

  // AND-OR select, all zeros when nothing is valid
  always_comb begin
    resp_rdata  = '0;
    resp_decerr = decerr_valid_q;
    resp_slverr = 1'b0;
    for (int i = 0; i < `CSR_NUM_BANKS; i++) begin
      if (bank_valid[i]) begin
        resp_rdata  = resp_rdata | bank_rdata[i];
        resp_decerr = resp_decerr | bank_decerr[i];
        resp_slverr = resp_slverr | bank_slverr[i];
      end
    end
  end

  assign resp_valid = decerr_valid_q || (|bank_valid);

  a_single_source: assert property (@(posedge clk) disable iff (rst)
    $onehot0({decerr_valid_q, bank_valid}))
    else $error("more than one response source valid in the same cycle");

endmodule

`default_nettype wire

// File: hdl/csr_retime.sv
/*
 * Valid-qualified retiming pipeline with no back-pressure.
 * STAGES of 0 gives a plain wire-through. Data only advances with its
 * valid, so payload in empty slots is stale. Abort shifts every cycle
 * and is meaningful only alongside valid at the far end.
 */
`timescale 1ns/1ps
`default_nettype none

module csr_retime #(
  parameter int STAGES = 1,
  parameter int WIDTH  = 1
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  input  logic [WIDTH-1:0] in_data,
  input  logic             in_abort,
  output logic             out_valid,
  output logic [WIDTH-1:0] out_data,
  output logic             out_abort
);

  if (STAGES == 0) begin : gen_bypass
    assign out_valid = in_valid;
    assign out_data  = in_data;
    assign out_abort = in_abort;
  end else begin : gen_pipe
    logic [STAGES-1:0] valid_q;
    logic [STAGES-1:0] abort_q;
    logic [WIDTH-1:0]  data_q [STAGES];

    // Several requests may be in flight, one per stage
    always_ff @(posedge clk) begin
      if (rst) begin
        valid_q <= '0;
      end else begin
        valid_q[0] <= in_valid;
        for (int i = 1; i < STAGES; i++) begin
          valid_q[i] <= valid_q[i-1];
        end
      end
    end

    always_ff @(posedge clk) begin
      if (in_valid) begin
        data_q[0] <= in_data;
      end
      for (int i = 1; i < STAGES; i++) begin
        if (valid_q[i-1]) begin
          data_q[i] <= data_q[i-1];
        end
      end
    end

    always_ff @(posedge clk) begin
      abort_q[0] <= in_abort;
      for (int i = 1; i < STAGES; i++) begin
        abort_q[i] <= abort_q[i-1];
      end
    end

    assign out_valid = valid_q[STAGES-1];
    assign out_data  = data_q[STAGES-1];
    assign out_abort = abort_q[STAGES-1];
  end

endmodule

`default_nettype wire

// File: hdl/csr_subsystem.sv
/*
 * CSR subsystem top: demux plus three register banks.
 * Single initiator, one request outstanding. The next request may only
 * be issued once the response pulse of the previous one has been seen.
 */
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_subsystem
  import csr_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      req_valid,
  input  logic      req_write,
  input  csr_addr_t req_addr,
  input  csr_data_t req_wdata,
  input  csr_strb_t req_wstrb,
  input  logic      req_privileged,
  input  logic      req_secure,
  input  logic      req_abort,
  output logic      resp_valid,
  output csr_data_t resp_rdata,
  output logic      resp_decerr,
  output logic      resp_slverr
);

  logic      [`CSR_NUM_BANKS-1:0] bank_req_valid;
  logic      [`CSR_NUM_BANKS-1:0] bank_req_write;
  csr_addr_t [`CSR_NUM_BANKS-1:0] bank_req_addr;
  csr_data_t [`CSR_NUM_BANKS-1:0] bank_req_wdata;
  csr_strb_t [`CSR_NUM_BANKS-1:0] bank_req_wstrb;
  logic      [`CSR_NUM_BANKS-1:0] bank_req_privileged;
  logic      [`CSR_NUM_BANKS-1:0] bank_req_secure;
  logic      [`CSR_NUM_BANKS-1:0] bank_req_abort;
  logic      [`CSR_NUM_BANKS-1:0] bank_resp_valid;
  csr_data_t [`CSR_NUM_BANKS-1:0] bank_resp_rdata;
  logic      [`CSR_NUM_BANKS-1:0] bank_resp_decerr;
  logic      [`CSR_NUM_BANKS-1:0] bank_resp_slverr;

  csr_demux u_demux (
    .clk                 (clk),
    .rst                 (rst),
    .req_valid           (req_valid),
    .req_write           (req_write),
    .req_addr            (req_addr),
    .req_wdata           (req_wdata),
    .req_wstrb           (req_wstrb),
    .req_privileged      (req_privileged),
    .req_secure          (req_secure),
    .req_abort           (req_abort),
    .resp_valid          (resp_valid),
    .resp_rdata          (resp_rdata),
    .resp_decerr         (resp_decerr),
    .resp_slverr         (resp_slverr),
    .bank_req_valid      (bank_req_valid),
    .bank_req_write      (bank_req_write),
    .bank_req_addr       (bank_req_addr),
    .bank_req_wdata      (bank_req_wdata),
    .bank_req_wstrb      (bank_req_wstrb),
    .bank_req_privileged (bank_req_privileged),
    .bank_req_secure     (bank_req_secure),
    .bank_req_abort      (bank_req_abort),
    .bank_resp_valid     (bank_resp_valid),
    .bank_resp_rdata     (bank_resp_rdata),
    .bank_resp_decerr    (bank_resp_decerr),
    .bank_resp_slverr    (bank_resp_slverr)
  );

  // Bank n reports n in its ID word
  for (genvar i = 0; i < `CSR_NUM_BANKS; i++) begin : gen_bank
    csr_reg_bank #(.BANK_ID(i)) u_bank (
      .clk            (clk),
      .rst            (rst),
      .req_valid      (bank_req_valid[i]),
      .req_write      (bank_req_write[i]),
      .req_addr       (bank_req_addr[i]),
      .req_wdata      (bank_req_wdata[i]),
      .req_wstrb      (bank_req_wstrb[i]),
      .req_privileged (bank_req_privileged[i]),
      .req_secure     (bank_req_secure[i]),
      .req_abort      (bank_req_abort[i]),
      .resp_valid     (bank_resp_valid[i]),
      .resp_rdata     (bank_resp_rdata[i]),
      .resp_decerr    (bank_resp_decerr[i]),
      .resp_slverr    (bank_resp_slverr[i])
    );
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the CSR testbench with Verilator
# Exit status is zero only when the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module csr_tb -o csr_tb_sim \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/csr_tb_sim > sim.log 2>&1
cat sim.log
grep -qx '>>> PASS' sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: tb.f
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_addr_decode.sv
hdl/csr_retime.sv
hdl/csr_reg_bank.sv
hdl/csr_resp_mux.sv
hdl/csr_demux.sv
hdl/csr_subsystem.sv
bench/csr_tb.sv
